//--- udp_port_pkg.sv
package udp_port_pkg;

    //////////////////////////////
    // Field widths
    //////////////////////////////
    localparam int MAC_WIDTH  = 48;
    localparam int IPV4_WIDTH = 32;
    localparam int PORT_WIDTH = 16;
    localparam int BYTE_WIDTH = 8;

    //////////////////////////////
    // Protocol constants
    //////////////////////////////
    localparam int          PREFIX_BYTES      = 14;  // Fabric message prefix
    localparam logic [15:0] ETHERTYPE_IPV4    = 16'h0800;
    localparam logic [7:0]  IPV4_VERSION_IHL  = 8'h45;
    localparam logic [7:0]  IPV4_TTL          = 8'd64;
    localparam logic [7:0]  IPV4_PROTOCOL_UDP = 8'd17;
    localparam logic [15:0] IPV4_FLAGS_DF     = 16'h4000;
    localparam int          IPV4_HEADER_BYTES = 20;
    localparam int          UDP_HEADER_BYTES  = 8;
    localparam int          MIN_FRAME_BYTES   = 60;  // FCS not counted
    localparam int          FCS_BYTES         = 4;
    localparam logic [31:0] CRC_POLYNOMIAL    = 32'hEDB88320;

    typedef logic [15:0] payload_length_t;

    typedef struct packed {
        logic [BYTE_WIDTH-1:0] data;
        logic                  last;
    } stream_byte_t;

    typedef struct packed {
        logic [MAC_WIDTH-1:0]  mac_destination;
        logic [IPV4_WIDTH-1:0] ipv4_destination;
        logic [PORT_WIDTH-1:0] udp_destination;
        logic [PORT_WIDTH-1:0] udp_source;
        payload_length_t       payload_length;
        logic                  bank;
    } frame_descriptor_t;

endpackage

//--- internet_checksum.sv
module internet_checksum (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [udp_port_pkg::BYTE_WIDTH-1:0] data,
    input  logic                                data_valid,
    input  logic                                data_last,
    output logic [15:0]                         result,
    output logic                                result_valid
);
    logic [15:0] sum;
    logic        low_byte;  // Next byte fills the low half of a word
    logic [15:0] word;
    logic [16:0] wide_sum;
    logic [15:0] sum_next;

    // Adding each half on its own is the same as adding the paired word
    assign word     = low_byte ? {8'h00, data} : {data, 8'h00};
    assign wide_sum = sum + word;
    assign sum_next = wide_sum[15:0] + 16'(wide_sum[16]);  // End-around carry

    always_ff @(posedge clock) begin
        if (rst) begin
            sum          <= '0;
            low_byte     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= data_valid && data_last;
            if (data_valid) begin
                if (data_last) begin
                    sum      <= '0;
                    low_byte <= 1'b0;
                end else begin
                    sum      <= sum_next;
                    low_byte <= ~low_byte;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (data_valid && data_last) begin
            result <= ~sum_next;
        end
    end

endmodule

//--- frame_check_sequence.sv
module frame_check_sequence (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                start,
    input  logic [udp_port_pkg::BYTE_WIDTH-1:0] data,
    input  logic                                data_valid,
    output logic [31:0]                         fcs
);
    import udp_port_pkg::*;

    logic [31:0] crc;
    logic [31:0] crc_next;

    // Reflected CRC-32, data bits taken LSB first
    always_comb begin
        crc_next = crc ^ {24'h000000, data};
        for (int i = 0; i < BYTE_WIDTH; i++) begin
            crc_next = crc_next[0] ? (crc_next >> 1) ^ CRC_POLYNOMIAL : crc_next >> 1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || start) begin
            crc <= '1;
        end else if (data_valid) begin
            crc <= crc_next;
        end
    end

    assign fcs = ~crc;

endmodule

//--- payload_buffer.sv
module payload_buffer #(
    parameter int PAYLOAD_MAX = 1472
) (
    input  logic                                clock,
    input  logic                                write_enable,
    input  logic                                write_bank,
    input  udp_port_pkg::payload_length_t       write_address,
    input  logic [udp_port_pkg::BYTE_WIDTH-1:0] write_data,
    input  logic                                read_bank,
    input  udp_port_pkg::payload_length_t       read_address,
    output logic [udp_port_pkg::BYTE_WIDTH-1:0] read_data
);
    import udp_port_pkg::*;

    localparam int DEPTH       = 2 * PAYLOAD_MAX;
    localparam int INDEX_WIDTH = $clog2(DEPTH);

    logic [BYTE_WIDTH-1:0]  memory [DEPTH];
    logic [INDEX_WIDTH-1:0] write_index;
    logic [INDEX_WIDTH-1:0] read_index;

    // Bank 1 sits directly above bank 0
    assign write_index = INDEX_WIDTH'(write_bank ? PAYLOAD_MAX + write_address : write_address);
    assign read_index  = INDEX_WIDTH'(read_bank ? PAYLOAD_MAX + read_address : read_address);

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_index] <= write_data;
        end
        read_data <= memory[read_index];  // Registered read
    end

endmodule

//--- udp_transmit_handler.sv
module udp_transmit_handler #(
    parameter int PAYLOAD_MAX = 1472
) (
    input  logic                                clock,
    input  logic                                rst,
    input  udp_port_pkg::stream_byte_t          module_data,
    input  logic                                module_valid,
    output logic                                module_ready,
    output udp_port_pkg::frame_descriptor_t     descriptor,
    output logic                                descriptor_valid,
    input  logic                                descriptor_ready,
    input  logic                                bank_release,
    output logic                                write_enable,
    output logic                                write_bank,
    output udp_port_pkg::payload_length_t       write_address,
    output logic [udp_port_pkg::BYTE_WIDTH-1:0] write_data
);
    import udp_port_pkg::*;

    localparam int PREFIX_WIDTH = MAC_WIDTH + IPV4_WIDTH + 2 * PORT_WIDTH;

    logic [PREFIX_WIDTH-1:0] prefix;
    logic [3:0]              prefix_count;
    payload_length_t         payload_count;
    logic [1:0]              bank_full;
    logic                    fill_bank;
    logic                    release_bank;  // Oldest full bank
    logic                    accept;
    logic                    in_payload;
    logic                    room;
    logic                    finish;

    // The free bank is always the fill bank, banks drain in fill order
    assign module_ready = ~&bank_full;
    assign accept       = module_valid && module_ready;
    assign in_payload   = prefix_count == PREFIX_BYTES;
    assign room         = payload_count < PAYLOAD_MAX;
    assign finish       = accept && module_data.last && in_payload;

    assign write_enable  = accept && in_payload && room;  // Overflow bytes dropped
    assign write_bank    = fill_bank;
    assign write_address = payload_count;
    assign write_data    = module_data.data;

    always_ff @(posedge clock) begin
        if (rst) begin
            prefix_count     <= '0;
            payload_count    <= '0;
            bank_full        <= '0;
            fill_bank        <= 1'b0;
            release_bank     <= 1'b0;
            descriptor_valid <= 1'b0;
        end else begin
            if (descriptor_valid && descriptor_ready) begin
                descriptor_valid <= 1'b0;
            end
            if (bank_release) begin
                bank_full[release_bank] <= 1'b0;
                release_bank            <= ~release_bank;
            end
            if (accept) begin
                if (module_data.last) begin
                    // Short message ends here without a descriptor
                    prefix_count  <= '0;
                    payload_count <= '0;
                end else if (!in_payload) begin
                    prefix_count <= prefix_count + 4'd1;
                end else if (room) begin
                    payload_count <= payload_count + 16'd1;
                end
            end
            if (finish) begin
                bank_full[fill_bank] <= 1'b1;
                fill_bank            <= ~fill_bank;
                descriptor_valid     <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Prefix and descriptor
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (accept && !in_payload) begin
            prefix <= {prefix[PREFIX_WIDTH-BYTE_WIDTH-1:0], module_data.data};  // MSB first
        end
        if (finish) begin
            {descriptor.mac_destination, descriptor.ipv4_destination,
             descriptor.udp_destination, descriptor.udp_source} <= prefix;
            descriptor.payload_length <= payload_count + payload_length_t'(room);
            descriptor.bank           <= fill_bank;
        end
    end

endmodule

//--- ethernet_frame_generator.sv
module ethernet_frame_generator #(
    parameter int PAYLOAD_MAX = 1472
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [udp_port_pkg::MAC_WIDTH-1:0]  mac_source,
    input  logic [udp_port_pkg::IPV4_WIDTH-1:0] ipv4_source,
    input  udp_port_pkg::frame_descriptor_t     descriptor,
    input  logic                                descriptor_valid,
    output logic                                descriptor_ready,
    output logic                                read_bank,
    output udp_port_pkg::payload_length_t       read_address,
    input  logic [udp_port_pkg::BYTE_WIDTH-1:0] read_data,
    output udp_port_pkg::stream_byte_t          frame_data,
    output logic                                frame_valid,
    input  logic                                frame_ready,
    output logic                                bank_release
);
    import udp_port_pkg::*;

    localparam int ETHERNET_HEADER_BYTES = 14;
    localparam int HEADER_BYTES = ETHERNET_HEADER_BYTES + IPV4_HEADER_BYTES + UDP_HEADER_BYTES;

    typedef enum logic [2:0] {IDLE, SUM, WAIT, SEND, CRC} state_t;

    state_t                            state;
    frame_descriptor_t                 current;
    payload_length_t                   length;
    payload_length_t                   count;  // Frame byte, or header byte while summing
    payload_length_t                   payload_address;
    payload_length_t                   payload_end;
    payload_length_t                   frame_end;
    payload_length_t                   header_index;
    logic [1:0]                        fcs_index;
    logic [15:0]                       identification;
    logic [15:0]                       ipv4_checksum;
    logic [0:HEADER_BYTES-1][BYTE_WIDTH-1:0] header;
    logic [BYTE_WIDTH-1:0]             header_byte;
    logic [BYTE_WIDTH-1:0]             send_byte;
    logic                              take;
    logic                              accept;
    logic                              in_payload;
    logic [15:0]                       checksum_result;
    logic                              checksum_valid;
    logic [31:0]                       fcs;

    assign length      = (current.payload_length > PAYLOAD_MAX) ?
                         payload_length_t'(PAYLOAD_MAX) : current.payload_length;
    assign payload_end = payload_length_t'(HEADER_BYTES) + length;
    assign frame_end   = (payload_end < MIN_FRAME_BYTES) ?
                         payload_length_t'(MIN_FRAME_BYTES) : payload_end;

    //////////////////////////////
    // Header bytes, wire order
    //////////////////////////////
    assign header = {current.mac_destination, mac_source, ETHERTYPE_IPV4,
                     IPV4_VERSION_IHL, 8'h00, length + 16'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES),
                     identification, IPV4_FLAGS_DF, IPV4_TTL, IPV4_PROTOCOL_UDP,
                     ipv4_checksum, ipv4_source, current.ipv4_destination,
                     current.udp_source, current.udp_destination,
                     length + 16'(UDP_HEADER_BYTES), 16'h0000};  // UDP checksum unused

    assign header_index = (state == SUM) ? count + 16'(ETHERNET_HEADER_BYTES) : count;
    assign header_byte  = header[header_index[5:0]];

    assign descriptor_ready = state == IDLE;
    assign take             = descriptor_valid && descriptor_ready;
    assign frame_valid      = (state == SEND) || (state == CRC);
    assign accept           = frame_valid && frame_ready;
    assign in_payload       = count >= HEADER_BYTES && count < payload_end;

    assign send_byte = (count < HEADER_BYTES) ? header_byte :
                       in_payload             ? read_data   : 8'h00;  // Padding

    assign frame_data.data = (state == CRC) ? fcs[8*fcs_index +: 8] : send_byte;
    assign frame_data.last = (state == CRC) && (fcs_index == 2'(FCS_BYTES - 1));

    // Prefetch keeps read_data one byte ahead of the accepted byte
    assign read_bank    = current.bank;
    assign read_address = payload_address + 16'(accept && state == SEND && in_payload);

    always_ff @(posedge clock) begin
        if (rst) begin
            state          <= IDLE;
            identification <= '0;
            bank_release   <= 1'b0;
        end else begin
            bank_release <= 1'b0;
            case (state)
                IDLE: begin
                    if (take) begin
                        current         <= descriptor;
                        count           <= '0;
                        payload_address <= '0;
                        fcs_index       <= '0;
                        ipv4_checksum   <= '0;  // Field is zero while summing
                        state           <= SUM;
                    end
                end
                SUM: begin
                    if (count == IPV4_HEADER_BYTES - 1) begin
                        count <= '0;
                        state <= WAIT;
                    end else begin
                        count <= count + 16'd1;
                    end
                end
                WAIT: begin
                    if (checksum_valid) begin
                        ipv4_checksum <= checksum_result;
                        state         <= SEND;
                    end
                end
                SEND: begin
                    if (accept) begin
                        count <= count + 16'd1;
                        if (in_payload) begin
                            payload_address <= payload_address + 16'd1;
                        end
                        if (count == frame_end - 16'd1) begin
                            state <= CRC;
                        end
                    end
                end
                CRC: begin
                    if (accept) begin
                        fcs_index <= fcs_index + 2'd1;
                        if (frame_data.last) begin
                            bank_release   <= 1'b1;
                            identification <= identification + 16'd1;
                            state          <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    internet_checksum ipv4_checksum_calculator (
        .clock        (clock),
        .rst          (rst),
        .data         (header_byte),
        .data_valid   (state == SUM),
        .data_last    (state == SUM && count == IPV4_HEADER_BYTES - 1),
        .result       (checksum_result),
        .result_valid (checksum_valid)
    );

    frame_check_sequence frame_check_sequence_generator (
        .clock      (clock),
        .rst        (rst),
        .start      (take),
        .data       (send_byte),
        .data_valid (accept && state == SEND),
        .fcs        (fcs)
    );

endmodule

//--- virtual_port_udp.sv
module virtual_port_udp #(
    parameter int PAYLOAD_MAX = 1472
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [udp_port_pkg::MAC_WIDTH-1:0]  mac_source,
    input  logic [udp_port_pkg::IPV4_WIDTH-1:0] ipv4_source,
    input  udp_port_pkg::stream_byte_t          module_data,
    input  logic                                module_valid,
    output logic                                module_ready,
    output udp_port_pkg::stream_byte_t          frame_data,
    output logic                                frame_valid,
    input  logic                                frame_ready
);
    import udp_port_pkg::*;

    frame_descriptor_t     descriptor;
    logic                  descriptor_valid;
    logic                  descriptor_ready;
    logic                  bank_release;
    logic                  write_enable;
    logic                  write_bank;
    payload_length_t       write_address;
    logic [BYTE_WIDTH-1:0] write_data;
    logic                  read_bank;
    payload_length_t       read_address;
    logic [BYTE_WIDTH-1:0] read_data;

    udp_transmit_handler #(.PAYLOAD_MAX(PAYLOAD_MAX)) udp_transmit_handler (
        .clock            (clock),
        .rst              (rst),
        .module_data      (module_data),
        .module_valid     (module_valid),
        .module_ready     (module_ready),
        .descriptor       (descriptor),
        .descriptor_valid (descriptor_valid),
        .descriptor_ready (descriptor_ready),
        .bank_release     (bank_release),
        .write_enable     (write_enable),
        .write_bank       (write_bank),
        .write_address    (write_address),
        .write_data       (write_data)
    );

    payload_buffer #(.PAYLOAD_MAX(PAYLOAD_MAX)) payload_buffer (
        .clock         (clock),
        .write_enable  (write_enable),
        .write_bank    (write_bank),
        .write_address (write_address),
        .write_data    (write_data),
        .read_bank     (read_bank),
        .read_address  (read_address),
        .read_data     (read_data)
    );

    ethernet_frame_generator #(.PAYLOAD_MAX(PAYLOAD_MAX)) ethernet_frame_generator (
        .clock            (clock),
        .rst              (rst),
        .mac_source       (mac_source),
        .ipv4_source      (ipv4_source),
        .descriptor       (descriptor),
        .descriptor_valid (descriptor_valid),
        .descriptor_ready (descriptor_ready),
        .read_bank        (read_bank),
        .read_address     (read_address),
        .read_data        (read_data),
        .frame_data       (frame_data),
        .frame_valid      (frame_valid),
        .frame_ready      (frame_ready),
        .bank_release     (bank_release)
    );

endmodule

//--- tb_virtual_port_udp.sv
module tb_virtual_port_udp;
    timeunit 1ns;
    timeprecision 1ps;

    import udp_port_pkg::*;

    localparam int NUM_MESSAGES   = 40;
    localparam int PAYLOAD_LIMIT  = 64;
    localparam int TIMEOUT_CYCLES = NUM_MESSAGES * 200 * 4;  // 200 cycles a message, 4x margin
    localparam int STALL_LIMIT    = 8;

    logic         clock = 1'b0;
    logic         rst;
    logic [47:0]  mac_source;
    logic [31:0]  ipv4_source;
    stream_byte_t module_data;
    logic         module_valid;
    logic         module_ready;
    stream_byte_t frame_data;
    logic         frame_valid;
    logic         frame_ready;

    integer       seed = 32'h99c67364;
    logic [7:0]   message_bytes [0:127];
    int           message_length;
    logic [8:0]   expected_bytes [$];  // {data, last}
    logic [8:0]   expected_entry;
    logic [15:0]  next_identification = '0;
    int           frames_expected = 0;
    int           frames_received = 0;
    int           frame_index = 0;
    int           byte_index = 0;
    int           mismatch_count = 0;
    int           failure_count = 0;
    int           stall_cycles = 0;
    int           cycle_count;

    virtual_port_udp #(.PAYLOAD_MAX(PAYLOAD_LIMIT)) DUT (
        .clock        (clock),
        .rst          (rst),
        .mac_source   (mac_source),
        .ipv4_source  (ipv4_source),
        .module_data  (module_data),
        .module_valid (module_valid),
        .module_ready (module_ready),
        .frame_data   (frame_data),
        .frame_valid  (frame_valid),
        .frame_ready  (frame_ready)
    );

    always #20 clock = ~clock;

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int random_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // One falling edge, new back-pressure value
    task automatic step();
        @(negedge clock);
        frame_ready = random_below(4) != 0;
    endtask

    //////////////////////////////
    // Frame model
    //////////////////////////////
    task automatic build_frame(input int kept);
        logic [7:0]  bytes [$];
        logic [15:0] total_length;
        logic [15:0] udp_length;
        logic [31:0] sum;
        logic [15:0] checksum;
        logic [31:0] crc;
        total_length = 16'(kept + 28);
        udp_length   = 16'(kept + 8);
        for (int i = 0; i < 6; i++) bytes.push_back(message_bytes[i]);
        for (int i = 5; i >= 0; i--) bytes.push_back(mac_source[8*i +: 8]);
        bytes.push_back(8'h08);
        bytes.push_back(8'h00);
        bytes.push_back(8'h45);
        bytes.push_back(8'h00);
        bytes.push_back(total_length[15:8]);
        bytes.push_back(total_length[7:0]);
        bytes.push_back(next_identification[15:8]);
        bytes.push_back(next_identification[7:0]);
        bytes.push_back(8'h40);  // DF
        bytes.push_back(8'h00);
        bytes.push_back(8'd64);
        bytes.push_back(8'd17);
        bytes.push_back(8'h00);  // Checksum, patched below
        bytes.push_back(8'h00);
        for (int i = 3; i >= 0; i--) bytes.push_back(ipv4_source[8*i +: 8]);
        for (int i = 6; i < 10; i++) bytes.push_back(message_bytes[i]);
        sum = '0;
        for (int i = 14; i < 34; i += 2) sum = sum + {16'h0000, bytes[i], bytes[i+1]};
        while (sum[31:16] != 16'h0000) sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        checksum  = ~sum[15:0];
        bytes[24] = checksum[15:8];
        bytes[25] = checksum[7:0];
        // UDP header, source port first
        bytes.push_back(message_bytes[12]);
        bytes.push_back(message_bytes[13]);
        bytes.push_back(message_bytes[10]);
        bytes.push_back(message_bytes[11]);
        bytes.push_back(udp_length[15:8]);
        bytes.push_back(udp_length[7:0]);
        bytes.push_back(8'h00);
        bytes.push_back(8'h00);
        for (int i = 0; i < kept; i++) bytes.push_back(message_bytes[14 + i]);
        while (bytes.size() < 60) bytes.push_back(8'h00);
        crc = 32'hFFFFFFFF;
        foreach (bytes[i]) begin
            crc = crc ^ {24'h000000, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? (crc >> 1) ^ 32'hEDB88320 : crc >> 1;
            end
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) bytes.push_back(crc[8*i +: 8]);  // LSB first
        foreach (bytes[i]) expected_bytes.push_back({bytes[i], i == bytes.size() - 1});
        next_identification = next_identification + 16'd1;
        frames_expected++;
    endtask

    //////////////////////////////
    // Fabric side stimulus
    //////////////////////////////
    task automatic drive_byte(input logic [7:0] value, input logic is_last);
        logic accepted;
        module_data.data = value;
        module_data.last = is_last;
        module_valid     = 1'b1;
        accepted         = 1'b0;
        while (!accepted) begin
            @(posedge clock);
            accepted = module_ready;
            step();
        end
        module_valid = 1'b0;
    endtask

    task automatic run_message();
        int payload_length;
        int gap;
        for (int i = 0; i < 14; i++) message_bytes[i] = random_byte();
        if (random_below(8) == 0) begin
            message_length = 1 + random_below(14);  // Ends inside the prefix
        end else begin
            payload_length = random_below(81);  // Zero means a bare prefix, no frame
            message_length = 14 + payload_length;
            for (int i = 14; i < message_length; i++) message_bytes[i] = random_byte();
            if (payload_length > 0) begin
                build_frame(payload_length > PAYLOAD_LIMIT ? PAYLOAD_LIMIT : payload_length);
            end
        end
        for (int i = 0; i < message_length; i++) begin
            drive_byte(message_bytes[i], i == message_length - 1);
        end
        gap = (random_below(4) == 0) ? 1 + random_below(12) : 0;
        repeat (gap) step();
    endtask

    task automatic finish_run();
        $display("Frames expected %0d, received %0d, mismatches %0d, other errors %0d",
                 frames_expected, frames_received, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    //////////////////////////////
    // Output checker
    //////////////////////////////
    always @(posedge clock) begin
        if (!rst && frame_valid && frame_ready) begin
            if (frame_data.last) begin
                frames_received++;  // Frames as the DUT marks them
            end
            if (expected_bytes.size() == 0) begin
                $display("Output byte %h arrived with no frame owed", frame_data.data);
                failure_count++;
            end else begin
                expected_entry = expected_bytes.pop_front();
                if (frame_data.data !== expected_entry[8:1]) begin
                    $display("MISMATCH frame_data.data frame %0d byte %0d expected %h actual %h",
                             frame_index, byte_index, expected_entry[8:1], frame_data.data);
                    mismatch_count++;
                end
                if (frame_data.last !== expected_entry[0]) begin
                    $display("MISMATCH frame_data.last frame %0d byte %0d expected %h actual %h",
                             frame_index, byte_index, expected_entry[0], frame_data.last);
                    mismatch_count++;
                end
                if (expected_entry[0]) begin
                    frame_index++;
                    byte_index = 0;
                end else begin
                    byte_index++;
                end
            end
        end
        // A short release delay is normal after the last frame leaves
        if (!rst && !module_ready && expected_bytes.size() == 0) begin
            stall_cycles++;
            if (stall_cycles == STALL_LIMIT) begin
                $display("module_ready stays low although every frame owed was read out");
                failure_count++;
            end
        end else begin
            stall_cycles = 0;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d output bytes still owed",
                 cycle_count, expected_bytes.size());
        failure_count++;
        finish_run();
    end

    initial begin
        rst          = 1'b1;
        mac_source   = 48'h02_1a_2b_3c_4d_5e;
        ipv4_source  = 32'hc0_a8_0a_01;
        module_data  = '0;
        module_valid = 1'b0;
        frame_ready  = 1'b0;
        repeat (10) @(negedge clock);
        rst = 1'b0;
        if (module_ready !== 1'b1) begin
            $display("MISMATCH module_ready after reset expected %h actual %h", 1'b1, module_ready);
            mismatch_count++;
        end
        if (frame_valid !== 1'b0) begin
            $display("MISMATCH frame_valid after reset expected %h actual %h", 1'b0, frame_valid);
            mismatch_count++;
        end
        for (int m = 0; m < NUM_MESSAGES; m++) begin
            run_message();
        end
        while (expected_bytes.size() != 0) step();
        repeat (20) step();  // Room for any extra bytes
        if (frames_received != frames_expected) begin
            $display("Expected %0d frames but received %0d", frames_expected, frames_received);
            failure_count++;
        end
        finish_run();
    end

endmodule

//--- virtual_port_udp.f
udp_port_pkg.sv
internet_checksum.sv
frame_check_sequence.sv
payload_buffer.sv
udp_transmit_handler.sv
ethernet_frame_generator.sv
virtual_port_udp.sv
tb_virtual_port_udp.sv

//--- Bender.yml
package:
  name: virtual_port_udp

sources:
  - udp_port_pkg.sv
  - internet_checksum.sv
  - frame_check_sequence.sv
  - payload_buffer.sv
  - udp_transmit_handler.sv
  - ethernet_frame_generator.sv
  - virtual_port_udp.sv
  - target: test
    files:
      - tb_virtual_port_udp.sv
